/* src/icv_settings.svh */
// icv update controller settings
// icache index geometry, core, thread and way counts
// cpx return-type codes as {valid, rtntyp}
`ifndef ICV_SETTINGS_SVH
`define ICV_SETTINGS_SVH

// --------------------------------------------------
// icache index geometry
// --------------------------------------------------
// top bit of the icache index
`define IC_IDX_HI 11
// icv write index, bits 11 down to 5
`define IC_IDX_SZ 7
// invalidate line index, bits 11 down to 6
`define INV_IDX_SZ 6

// --------------------------------------------------
// system size
// --------------------------------------------------
// cores sharing the cpx invalidate vector
`define NUM_CORES 8
// threads per core, one saved load index each
`define NUM_THREADS 4
// icache associativity
`define NUM_WAYS 4

// --------------------------------------------------
// cpx return types, valid bit then 4-bit type
// --------------------------------------------------
`define CPX_LDPKT    5'b10000
`define CPX_IFILLPKT 5'b10001
`define CPX_EVPKT    5'b10011
`define CPX_STRPKT   5'b10100
`define CPX_STRMACK  5'b10110

`endif

/* src/icv_pkg.sv */
// icv package
// index, way, thread and core vector types
// cpx return packet and the per-core decode result
`include "icv_settings.svh"

package icv_pkg;

   // --------------------------------------------------
   // plain vectors
   // --------------------------------------------------
   // icache index, bits 11..5
   typedef logic [`IC_IDX_HI:`IC_IDX_HI-`IC_IDX_SZ+1] ic_index_t;
   // invalidate line index, bits 11..6
   typedef logic [`IC_IDX_HI:`IC_IDX_HI-`INV_IDX_SZ+1] inv_index_t;

   typedef logic [$clog2(`NUM_WAYS)-1:0] way_t;
   typedef logic [`NUM_WAYS-1:0] way_dec_t;
   typedef logic [$clog2(`NUM_THREADS)-1:0] thread_id_t;
   typedef logic [$clog2(`NUM_CORES)-1:0] core_id_t;

   // one enable per 32B group, group = {idx[6], word}
   typedef logic [3:0] word_en_t;
   // bit 4*group + way
   typedef logic [4*`NUM_WAYS-1:0] icv_wren_t;

   // --------------------------------------------------
   // cpx packet
   // --------------------------------------------------
   // one core's entry in a word invalidate vector
   typedef struct packed {
      logic vld;
      way_t way;
   } inv_entry_t;

   typedef struct packed {
      logic                          valid;
      logic [3:0]                    rtntyp;
      // load hit the icache, ld_way is meaningful
      logic                          wyvld;
      way_t                          ld_way;
      thread_id_t                    thrid;
      // invalidate all ways of the line
      logic                          iinv;
      logic                          invpa5;
      inv_index_t                    inv_idx;
      inv_entry_t [`NUM_CORES-1:0]   inv_word0;
      inv_entry_t [`NUM_CORES-1:0]   inv_word1;
   } cpx_pkt_t;

   // --------------------------------------------------
   // decode result for this core
   // --------------------------------------------------
   typedef struct packed {
      logic       ld_inv;
      logic       imiss_rtn;
      // store ack, evict or stream-store ack
      logic       st_ev;
      logic       iinv;
      logic       invpa5;
      logic       word0_inv;
      logic       word1_inv;
      way_t       word0_way;
      way_t       word1_way;
      way_t       ld_way;
      thread_id_t thrid;
      inv_index_t inv_idx;
   } inv_info_t;

endpackage

/* src/cpx_inv_decode.sv */
// cpx return packet decode
// return type compare, this core's invalidate entries,
// pass-through of thread, index and load way
`timescale 1ns/1ps
`include "icv_settings.svh"

module cpx_inv_decode
   import icv_pkg::*;
(
   input  cpx_pkt_t  cpx_pkt,
   input  core_id_t  cpuid,
   output inv_info_t inv_info
);

   // --------------------------------------------------
   // return type
   // --------------------------------------------------
   logic [4:0] rtn;
   logic       ldpkt;
   logic       ifillpkt;
   logic       evpkt;
   logic       stpkt;
   logic       strmack;

   // this core's slice of each word vector
   inv_entry_t word0_ent;
   inv_entry_t word1_ent;

   // valid bit folds into the compare, idle packet matches nothing
   assign rtn = {cpx_pkt.valid, cpx_pkt.rtntyp};

   assign ldpkt    = (rtn == `CPX_LDPKT);
   assign ifillpkt = (rtn == `CPX_IFILLPKT);
   assign evpkt    = (rtn == `CPX_EVPKT);
   assign stpkt    = (rtn == `CPX_STRPKT);
   assign strmack  = (rtn == `CPX_STRMACK);

   // --------------------------------------------------
   // per-core invalidate vector
   // --------------------------------------------------
   // 8:1 pick by core id, both words
   assign word0_ent = cpx_pkt.inv_word0[cpuid];
   assign word1_ent = cpx_pkt.inv_word1[cpuid];

   // --------------------------------------------------
   // decode result
   // --------------------------------------------------
   always_comb begin
      // load that hit the icache, must drop the line
      inv_info.ld_inv    = ldpkt & cpx_pkt.wyvld;
      inv_info.imiss_rtn = ifillpkt;

      // any of the three invalidating acks
      inv_info.st_ev     = stpkt | evpkt | strmack;

      // invalidate-all is only defined on store acks
      inv_info.iinv      = stpkt & cpx_pkt.iinv;
      inv_info.invpa5    = cpx_pkt.invpa5;

      // word 0 covers pa[5]=0, word 1 pa[5]=1
      inv_info.word0_inv = word0_ent.vld;
      inv_info.word1_inv = word1_ent.vld;
      inv_info.word0_way = word0_ent.way;
      inv_info.word1_way = word1_ent.way;

      // straight from the packet
      inv_info.ld_way    = cpx_pkt.ld_way;
      inv_info.thrid     = cpx_pkt.thrid;
      inv_info.inv_idx   = cpx_pkt.inv_idx;
   end

endmodule

/* src/ld_index_table.sv */
// load index table
// one saved icache index per thread, written on load issue,
// read combinationally by the returning packet's thread
`timescale 1ns/1ps
`include "icv_settings.svh"

module ld_index_table
   import icv_pkg::*;
(
   input  logic       rclk,
   input  logic       rst_n,
   input  ic_index_t  ld_idx,
   input  logic       ld_vld,
   input  thread_id_t ld_tid,
   input  thread_id_t rd_tid,
   output ic_index_t  ld_inv_idx
);

   // one entry per thread
   ic_index_t ld_idx_tbl [`NUM_THREADS];

   // one-hot write select from the issuing thread
   logic [`NUM_THREADS-1:0] wr_sel;

   // --------------------------------------------------
   // write side
   // --------------------------------------------------
   always_comb begin
      wr_sel = '0;
      if (ld_vld) begin
         wr_sel[ld_tid] = 1'b1;
      end
   end

   // entry visible to the read port from the next cycle
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         for (int t = 0; t < `NUM_THREADS; t++) begin
            ld_idx_tbl[t] <= '0;
         end
      end else begin
         for (int t = 0; t < `NUM_THREADS; t++) begin
            if (wr_sel[t]) begin
               ld_idx_tbl[t] <= ld_idx;
            end
         end
      end
   end

   // --------------------------------------------------
   // read side
   // --------------------------------------------------
   // index of the load now coming back on cpx
   assign ld_inv_idx = ld_idx_tbl[rd_tid];

endmodule

/* src/icv_update_ctl.sv */
// icv update control
// way select, word enables, 16-bit write enable with invalidate-all,
// write index mux, invalidate request with stall hold, asi way
`timescale 1ns/1ps
`include "icv_settings.svh"

module icv_update_ctl
   import icv_pkg::*;
(
   input  logic      rclk,
   input  logic      rst_n,
   input  inv_info_t inv_info,
   input  ic_index_t ld_inv_idx,
   input  way_t      wrway,
   input  ic_index_t ifill_idx,
   input  logic      ifq_adv,
   input  logic      asi_req,
   input  logic      bist_wr,
   output ic_index_t icv_wrindex,
   output icv_wren_t icv_wren,
   output way_dec_t  dec_wrway,
   output logic      inv_req,
   output logic      inv_pending,
   output way_t      asi_way
);

   // held state, recirculates while ifq stalls
   way_t [1:0] way_f;
   word_en_t   wen_f;
   logic       inv_f;

   // packet word info, index 0/1 = word 0/1
   logic [1:0] word_inv;
   way_t [1:0] word_way;

   way_t [1:0] way_sel;
   logic       wr_req;
   logic       pick_wr;
   logic       invall;
   word_en_t   wen_new;
   word_en_t   wen_bf;
   logic       inv_new;
   logic       inv_bf;
   logic       sel_wr;
   logic       sel_ld;

   // 2-bit way to one-hot
   function automatic way_dec_t dec_way(input way_t way);
      way_dec_t dec;
      dec = '0;
      dec[way] = 1'b1;
      return dec;
   endfunction

   assign word_inv = {inv_info.word1_inv, inv_info.word0_inv};
   assign word_way = {inv_info.word1_way, inv_info.word0_way};

   // ifill, asi or bist write of the valid array
   assign wr_req  = inv_info.imiss_rtn | asi_req | bist_wr;
   // bist runs alone, no need to wait for advance
   assign pick_wr = (inv_info.imiss_rtn | asi_req) & ifq_adv | bist_wr;

   // --------------------------------------------------
   // way select per word
   // --------------------------------------------------
   always_comb begin
      for (int w = 0; w < 2; w++) begin
         if (pick_wr) begin
            way_sel[w] = wrway;
         end else if (!ifq_adv) begin
            way_sel[w] = way_f[w];
         end else if (inv_info.ld_inv) begin
            // load hit, same way for both words
            way_sel[w] = inv_info.ld_way;
         end else begin
            way_sel[w] = word_way[w];
         end
      end
   end

   // tag write way
   assign dec_wrway = dec_way(wrway);

   // --------------------------------------------------
   // word enables, group g = {idx[6], word}
   // --------------------------------------------------
   always_comb begin
      logic [1:0] grp;
      wen_new = '0;
      for (int g = 0; g < 4; g++) begin
         grp = 2'(g);
         wen_new[g] = (inv_info.st_ev & word_inv[grp[0]] &
                       (inv_info.inv_idx[6] == grp[1])) |
                      (inv_info.ld_inv & (ld_inv_idx[6:5] == grp)) |
                      (wr_req & (ifill_idx[6:5] == grp));
      end
   end

   assign wen_bf = ifq_adv ? wen_new : wen_f;

   // --------------------------------------------------
   // final write enable
   // --------------------------------------------------
   // store with iinv clears every way of the 32B half
   assign invall = inv_info.iinv & ifq_adv;

   always_comb begin
      logic [1:0] grp;
      logic       all_hit;
      for (int g = 0; g < 4; g++) begin
         grp = 2'(g);
         all_hit = invall & (inv_info.invpa5 == grp[0]) &
                   (inv_info.inv_idx[6] == grp[1]);
         // even groups take word 0 way, odd groups word 1
         icv_wren[g*`NUM_WAYS +: `NUM_WAYS] =
            (dec_way(way_sel[grp[0]]) & {`NUM_WAYS{wen_bf[g]}}) |
            {`NUM_WAYS{all_hit}};
      end
   end

   // --------------------------------------------------
   // write index
   // --------------------------------------------------
   // stalled writes keep pointing at the ifill index
   assign sel_wr = wr_req | ~ifq_adv;
   assign sel_ld = inv_info.ld_inv & ifq_adv;

   always_comb begin
      if (sel_wr) begin
         icv_wrindex = ifill_idx;
      end else if (sel_ld) begin
         icv_wrindex = ld_inv_idx;
      end else begin
         // line invalidate, both 32B halves share bit 5 = 0
         icv_wrindex = {inv_info.inv_idx, 1'b0};
      end
   end

   // --------------------------------------------------
   // invalidate request
   // --------------------------------------------------
   assign inv_new = inv_info.st_ev & (|word_inv | inv_info.iinv) |
                    inv_info.ld_inv;
   assign inv_bf  = ifq_adv ? inv_new : inv_f;

   // bist auto-invalidates
   assign inv_req     = inv_bf | bist_wr;
   assign inv_pending = inv_new;

   // --------------------------------------------------
   // held registers and asi way
   // --------------------------------------------------
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         way_f   <= '0;
         wen_f   <= '0;
         inv_f   <= 1'b0;
         asi_way <= '0;
      end else begin
         way_f   <= ifq_adv ? way_sel : way_f;
         wen_f   <= wen_bf;
         inv_f   <= inv_bf;
         // asi readback of the written way, one cycle later
         asi_way <= wrway;
      end
   end

endmodule

/* src/ifu_inv_ctl.sv */
// icache invalidate control, top level
// cpx decode, per-thread load index table and icv update control
`timescale 1ns/1ps
`include "icv_settings.svh"

module ifu_inv_ctl
   import icv_pkg::*;
(
   input  logic       rclk,
   input  logic       rst_n,
   input  core_id_t   cpuid,
   input  cpx_pkt_t   cpx_pkt,
   input  way_t       wrway,
   input  ic_index_t  ifill_idx,
   input  ic_index_t  ld_idx,
   input  logic       ld_vld,
   input  thread_id_t ld_tid,
   input  logic       ifq_adv,
   input  logic       asi_req,
   input  logic       bist_wr,
   output ic_index_t  icv_wrindex,
   output icv_wren_t  icv_wren,
   output way_dec_t   dec_wrway,
   output logic       inv_req,
   output logic       inv_pending,
   output way_t       asi_way
);

   // decoded packet for this core
   inv_info_t inv_info;
   // saved load index of the returning thread
   ic_index_t ld_inv_idx;

   // --------------------------------------------------
   // packet decode
   // --------------------------------------------------
   cpx_inv_decode i_decode (
      .cpx_pkt  (cpx_pkt),
      .cpuid    (cpuid),
      .inv_info (inv_info)
   );

   // --------------------------------------------------
   // load index per thread
   // --------------------------------------------------
   ld_index_table i_ld_table (
      .rclk       (rclk),
      .rst_n      (rst_n),
      .ld_idx     (ld_idx),
      .ld_vld     (ld_vld),
      .ld_tid     (ld_tid),
      .rd_tid     (inv_info.thrid),
      .ld_inv_idx (ld_inv_idx)
   );

   // --------------------------------------------------
   // icv update
   // --------------------------------------------------
   icv_update_ctl i_update (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .inv_info    (inv_info),
      .ld_inv_idx  (ld_inv_idx),
      .wrway       (wrway),
      .ifill_idx   (ifill_idx),
      .ifq_adv     (ifq_adv),
      .asi_req     (asi_req),
      .bist_wr     (bist_wr),
      .icv_wrindex (icv_wrindex),
      .icv_wren    (icv_wren),
      .dec_wrway   (dec_wrway),
      .inv_req     (inv_req),
      .inv_pending (inv_pending),
      .asi_way     (asi_way)
   );

endmodule

/* bench/tb_icv_tasks.svh */
// testbench tasks for the icache invalidate controller
// value check, drive helpers, expected enables and directed tests
`ifndef TB_ICV_TASKS_SVH
`define TB_ICV_TASKS_SVH

// --------------------------------------------------
// helpers
// --------------------------------------------------
task automatic compare_value(input logic [31:0] act, input logic [31:0] exp,
                             input string what);
   if (act !== exp) begin
      $display("[FAIL] time %0t %s: got %0h, expected %0h", $time, what, act, exp);
      $display("Regression failed");
      $fatal(1, "value mismatch on %s", what);
   end
endtask

// drive point 1 ns after the rising edge
task automatic next_cycle();
   @(posedge rclk);
   #1;
endtask

// combinational outputs stable well before the next edge
task automatic settle();
   #5;
endtask

task automatic idle_inputs();
   cpx_pkt = '0;
   ld_vld  = 1'b0;
   asi_req = 1'b0;
   bist_wr = 1'b0;
endtask

// enable bit of way w in group g
function automatic logic [31:0] wren_bit(input int g, input int w);
   return 32'd1 << (4 * g + w);
endfunction

// group from index bits 6 and 5
function automatic int idx_group(input ic_index_t idx);
   return int'(idx[6:5]);
endfunction

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic idle_after_reset();
   idle_inputs();
   ifq_adv = 1'b0;
   next_cycle();
   settle();
   compare_value(32'(icv_wren), 32'd0, "idle icv_wren");
   compare_value(32'(inv_req), 32'd0, "idle inv_req");
   compare_value(32'(inv_pending), 32'd0, "idle inv_pending");
endtask

task automatic ifill_asi_writes();
   ic_index_t idx;
   int        w;
   int        g;
   int        prev_w;
   // wrway sat at zero through reset
   prev_w  = 0;
   ifq_adv = 1'b1;
   // one index per group
   for (int i = 0; i < 4; i++) begin
      w   = $random(seed) & 3;
      // a fresh way each pass so the asi lag shows
      if (w == prev_w) begin
         w = (w + 1) & 3;
      end
      idx = 7'(i * 37 + 5);
      g   = idx_group(idx);
      next_cycle();
      idle_inputs();
      cpx_pkt.valid  = 1'b1;
      cpx_pkt.rtntyp = 4'b0001;
      wrway          = 2'(w);
      ifill_idx      = idx;
      settle();
      // asi way still shows the previous write
      compare_value(32'(asi_way), 32'(prev_w), "asi_way before write");
      compare_value(32'(icv_wren), wren_bit(g, w), "ifill icv_wren");
      compare_value(32'(icv_wrindex), 32'(idx), "ifill icv_wrindex");
      compare_value(32'(dec_wrway), 32'd1 << w, "ifill dec_wrway");
      // asi write next with no packet
      next_cycle();
      idle_inputs();
      asi_req = 1'b1;
      settle();
      compare_value(32'(asi_way), 32'(w), "asi_way one cycle on");
      compare_value(32'(icv_wren), wren_bit(g, w), "asi icv_wren");
      compare_value(32'(icv_wrindex), 32'(idx), "asi icv_wrindex");
      compare_value(32'(dec_wrway), 32'd1 << w, "asi dec_wrway");
      prev_w = w;
   end
endtask

task automatic evict_invalidate();
   inv_index_t  iidx;
   logic [31:0] exp;
   int          core;
   int          nb;
   int          w0;
   int          w1;
   int          h;
   ifq_adv = 1'b1;
   for (int i = 0; i < 4; i++) begin
      core = (i * 3 + 1) % `NUM_CORES;
      nb   = (core + 1) % `NUM_CORES;
      w0   = $random(seed) & 3;
      w1   = $random(seed) & 3;
      iidx = 6'(i * 11 + 3);
      h    = int'(iidx[6]);
      next_cycle();
      idle_inputs();
      cpuid           = 3'(core);
      cpx_pkt.valid   = 1'b1;
      cpx_pkt.rtntyp  = 4'b0011;
      cpx_pkt.inv_idx = iidx;
      cpx_pkt.inv_word0[core].vld = 1'b1;
      cpx_pkt.inv_word0[core].way = 2'(w0);
      // last pass sets word 0 only
      cpx_pkt.inv_word1[core].vld = (i != 3);
      cpx_pkt.inv_word1[core].way = 2'(w1);
      // neighbour core with other ways is ignored
      cpx_pkt.inv_word0[nb].vld = 1'b1;
      cpx_pkt.inv_word0[nb].way = 2'(~w0);
      cpx_pkt.inv_word1[nb].vld = 1'b1;
      cpx_pkt.inv_word1[nb].way = 2'(~w1);
      exp = wren_bit(2 * h, w0);
      if (i != 3) begin
         exp = exp | wren_bit(2 * h + 1, w1);
      end
      settle();
      compare_value(32'(icv_wren), exp, "evict icv_wren");
      compare_value(32'(icv_wrindex), 32'({iidx, 1'b0}), "evict icv_wrindex");
      compare_value(32'(inv_pending), 32'd1, "evict inv_pending");
      compare_value(32'(inv_req), 32'd1, "evict inv_req");
   end
   // only core 5 named while this core is 0
   next_cycle();
   idle_inputs();
   cpuid          = 3'd0;
   cpx_pkt.valid  = 1'b1;
   cpx_pkt.rtntyp = 4'b0011;
   cpx_pkt.inv_word0[5].vld = 1'b1;
   cpx_pkt.inv_word1[5].vld = 1'b1;
   settle();
   compare_value(32'(icv_wren), 32'd0, "foreign evict icv_wren");
   compare_value(32'(inv_pending), 32'd0, "foreign evict inv_pending");
   compare_value(32'(inv_req), 32'd0, "foreign evict inv_req");
endtask

// load return for thread t with stored index exp_idx
task automatic load_return(input int t, input ic_index_t exp_idx);
   int w;
   w = $random(seed) & 3;
   next_cycle();
   idle_inputs();
   cpx_pkt.valid  = 1'b1;
   cpx_pkt.rtntyp = 4'b0000;
   cpx_pkt.wyvld  = 1'b1;
   cpx_pkt.thrid  = 2'(t);
   cpx_pkt.ld_way = 2'(w);
   settle();
   compare_value(32'(icv_wrindex), 32'(exp_idx), "load icv_wrindex");
   compare_value(32'(icv_wren), wren_bit(idx_group(exp_idx), w), "load icv_wren");
   compare_value(32'(inv_pending), 32'd1, "load inv_pending");
   compare_value(32'(inv_req), 32'd1, "load inv_req");
endtask

task automatic load_invalidate();
   ic_index_t idx_a;
   ic_index_t idx_b;
   idx_a   = 7'b1010110;
   idx_b   = 7'b0100011;
   ifq_adv = 1'b1;
   // two load issues for threads 2 then 1
   next_cycle();
   idle_inputs();
   ld_vld = 1'b1;
   ld_tid = 2'd2;
   ld_idx = idx_a;
   next_cycle();
   ld_tid = 2'd1;
   ld_idx = idx_b;
   load_return(2, idx_a);
   load_return(1, idx_b);
endtask

task automatic invalidate_all();
   inv_index_t iidx;
   int         g;
   ifq_adv = 1'b1;
   for (int p = 0; p < 2; p++) begin
      iidx = 6'(p * 21 + 4);
      g    = 2 * int'(iidx[6]) + p;
      next_cycle();
      idle_inputs();
      cpx_pkt.valid   = 1'b1;
      cpx_pkt.rtntyp  = 4'b0100;
      cpx_pkt.iinv    = 1'b1;
      cpx_pkt.invpa5  = 1'(p);
      cpx_pkt.inv_idx = iidx;
      settle();
      compare_value(32'(icv_wren), 32'hf << (4 * g), "iinv icv_wren");
      compare_value(32'(inv_req), 32'd1, "iinv inv_req");
   end
endtask

task automatic stall_hold_bist();
   logic [31:0] exp;
   ic_index_t   idx;
   int          w0;
   int          w1;
   int          w;
   w0      = $random(seed) & 3;
   w1      = $random(seed) & 3;
   ifq_adv = 1'b1;
   // advancing evict with index bit 6 set so groups 2 and 3
   next_cycle();
   idle_inputs();
   cpuid           = 3'd6;
   cpx_pkt.valid   = 1'b1;
   cpx_pkt.rtntyp  = 4'b0011;
   cpx_pkt.inv_idx = 6'd9;
   cpx_pkt.inv_word0[6].vld = 1'b1;
   cpx_pkt.inv_word0[6].way = 2'(w0);
   cpx_pkt.inv_word1[6].vld = 1'b1;
   cpx_pkt.inv_word1[6].way = 2'(w1);
   exp = wren_bit(2, w0) | wren_bit(3, w1);
   settle();
   compare_value(32'(icv_wren), exp, "pre-stall icv_wren");
   // two stalled cycles with an idle packet
   for (int k = 0; k < 2; k++) begin
      next_cycle();
      idle_inputs();
      ifq_adv   = 1'b0;
      ifill_idx = 7'h35;
      settle();
      compare_value(32'(icv_wren), exp, "stall icv_wren");
      compare_value(32'(inv_req), 32'd1, "stall inv_req");
      compare_value(32'(inv_pending), 32'd0, "stall inv_pending");
      compare_value(32'(icv_wrindex), 32'h35, "stall icv_wrindex");
   end
   // bist write
   w   = $random(seed) & 3;
   idx = 7'h4a;
   next_cycle();
   idle_inputs();
   ifq_adv   = 1'b1;
   bist_wr   = 1'b1;
   wrway     = 2'(w);
   ifill_idx = idx;
   settle();
   compare_value(32'(icv_wren), wren_bit(idx_group(idx), w), "bist icv_wren");
   compare_value(32'(inv_req), 32'd1, "bist inv_req");
   compare_value(32'(icv_wrindex), 32'(idx), "bist icv_wrindex");
   next_cycle();
   idle_inputs();
endtask

`endif

/* bench/tb_ifu_inv_ctl.sv */
// testbench for the icache invalidate controller
// clock, reset, DUT instance, cycle timeout and test sequence
`timescale 1ns/1ps
`include "icv_settings.svh"

module tb_ifu_inv_ctl
   import icv_pkg::*;
();

   // generous margin over the ~41-cycle directed sequence
   localparam int TIMEOUT_CYCLES = 400;

   // --------------------------------------------------
   // DUT signals
   // --------------------------------------------------
   logic       rclk;
   logic       rst_n;
   core_id_t   cpuid;
   cpx_pkt_t   cpx_pkt;
   way_t       wrway;
   ic_index_t  ifill_idx;
   ic_index_t  ld_idx;
   logic       ld_vld;
   thread_id_t ld_tid;
   logic       ifq_adv;
   logic       asi_req;
   logic       bist_wr;
   ic_index_t  icv_wrindex;
   icv_wren_t  icv_wren;
   way_dec_t   dec_wrway;
   logic       inv_req;
   logic       inv_pending;
   way_t       asi_way;

   // random way fields
   int seed;
   int cycle_cnt = 0;

   ifu_inv_ctl i_dut (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .cpuid       (cpuid),
      .cpx_pkt     (cpx_pkt),
      .wrway       (wrway),
      .ifill_idx   (ifill_idx),
      .ld_idx      (ld_idx),
      .ld_vld      (ld_vld),
      .ld_tid      (ld_tid),
      .ifq_adv     (ifq_adv),
      .asi_req     (asi_req),
      .bist_wr     (bist_wr),
      .icv_wrindex (icv_wrindex),
      .icv_wren    (icv_wren),
      .dec_wrway   (dec_wrway),
      .inv_req     (inv_req),
      .inv_pending (inv_pending),
      .asi_way     (asi_way)
   );

   `include "tb_icv_tasks.svh"

   // 40 ns clock
   initial begin
      rclk = 1'b0;
      forever begin
         #20 rclk = ~rclk;
      end
   end

   // run limit
   always @(posedge rclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
         $display("Regression failed");
         $fatal(1, "simulation timed out");
      end
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      seed      = 10623;
      rst_n     = 1'b0;
      cpuid     = '0;
      cpx_pkt   = '0;
      wrway     = '0;
      ifill_idx = '0;
      ld_idx    = '0;
      ld_vld    = 1'b0;
      ld_tid    = '0;
      ifq_adv   = 1'b0;
      asi_req   = 1'b0;
      bist_wr   = 1'b0;
      // 16 cycles in reset
      repeat (16) @(posedge rclk);
      #1 rst_n = 1'b1;

      idle_after_reset();
      ifill_asi_writes();
      evict_invalidate();
      load_invalidate();
      invalidate_all();
      stall_hold_bist();

      $display("Regression passed");
      $finish;
   end

endmodule

/* list.f */
+incdir+src
+incdir+bench
src/icv_pkg.sv
src/cpx_inv_decode.sv
src/ld_index_table.sv
src/icv_update_ctl.sv
src/ifu_inv_ctl.sv
bench/tb_ifu_inv_ctl.sv

/* run.sh */
#!/bin/sh
# build and run the icv controller regression with verilator
# exit status is nonzero when the run fails
cd "$(dirname "$0")" \
   && verilator --binary --timing -j 0 --top-module tb_ifu_inv_ctl -f list.f -o sim_tb \
   && ./obj_dir/sim_tb \
   || exit 1
